// File: i3c_target_pkg.sv
// Shared constants and types of the standby target; SDR private transfers only, no CCC, DAA or IBI
package i3c_target_pkg;

  localparam int DATA_W         = 32;
  localparam int BYTES_PER_WORD = 4;
  localparam int SYNC_STAGES    = 2;
  localparam int ADDR_W         = 7;
  localparam int BYTE_IDX_W     = $clog2(BYTES_PER_WORD);

  localparam logic [BYTE_IDX_W-1:0] LAST_BYTE_IDX = BYTE_IDX_W'(BYTES_PER_WORD - 1);

  // Configuration register select
  localparam logic [1:0] CFG_SEL_CTRL   = 2'd0;
  localparam logic [1:0] CFG_SEL_STATIC = 2'd1;
  localparam logic [1:0] CFG_SEL_DYN    = 2'd2;

  typedef struct packed {
    logic       strobe;
    logic [1:0] sel;
    logic [7:0] value;
  } cfg_wr_t;

  typedef struct packed {
    logic              enable;
    logic [ADDR_W-1:0] static_addr;
    logic [ADDR_W-1:0] dyn_addr;
    logic              dyn_valid;
  } target_cfg_t;

  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_evt_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       last;
  } rx_byte_t;

  typedef struct packed {
    logic active;
    logic rnw;
  } xfer_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_ADDR_ACK,
    ST_WDATA,
    ST_WACK,
    ST_RDATA,
    ST_RACK
  } tgt_state_e;

endpackage

// File: i3c_bus_monitor.sv
// Line monitor for a slow SCL; events are single-cycle pulses SYNC_STAGES+1 cycles after the pins
module i3c_bus_monitor (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      scl_i,
  input  logic                      sda_i,
  output i3c_target_pkg::bus_evt_t  evt_o
);

  logic [i3c_target_pkg::SYNC_STAGES-1:0] scl_sync_q;
  logic [i3c_target_pkg::SYNC_STAGES-1:0] sda_sync_q;
  logic                                   scl_prev_q;
  logic                                   sda_prev_q;
  logic                                   scl_s;
  logic                                   sda_s;

  assign scl_s = scl_sync_q[i3c_target_pkg::SYNC_STAGES-1];
  assign sda_s = sda_sync_q[i3c_target_pkg::SYNC_STAGES-1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Idle bus is high on both lines
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      evt_o      <= '{start: 1'b0, stop: 1'b0, scl_rise: 1'b0, scl_fall: 1'b0, sda: 1'b1};
    end else begin
      scl_sync_q <= {scl_sync_q[i3c_target_pkg::SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[i3c_target_pkg::SYNC_STAGES-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;

      // SDA moving under a high SCL is a bus condition
      evt_o.start    <= scl_s && scl_prev_q && sda_prev_q && !sda_s;
      evt_o.stop     <= scl_s && scl_prev_q && !sda_prev_q && sda_s;
      evt_o.scl_rise <= scl_s && !scl_prev_q;
      evt_o.scl_fall <= !scl_s && scl_prev_q;
      evt_o.sda      <= sda_s;
    end
  end

endmodule

// File: i3c_addr_cfg.sv
// Enable and address registers; a write lands the next cycle, the match output is combinational
module i3c_addr_cfg (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  i3c_target_pkg::cfg_wr_t             cfg_wr_i,
  input  logic [i3c_target_pkg::ADDR_W-1:0]   bus_addr_i,
  output i3c_target_pkg::target_cfg_t         cfg_o,
  output logic                                addr_match_o
);

  i3c_target_pkg::target_cfg_t cfg_q;
  logic                        sta_hit;
  logic                        dyn_hit;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (cfg_wr_i.strobe) begin
      case (cfg_wr_i.sel)
        i3c_target_pkg::CFG_SEL_CTRL: begin
          cfg_q.enable <= cfg_wr_i.value[0];
        end
        i3c_target_pkg::CFG_SEL_STATIC: begin
          cfg_q.static_addr <= cfg_wr_i.value[i3c_target_pkg::ADDR_W-1:0];
        end
        i3c_target_pkg::CFG_SEL_DYN: begin
          // Assigned address becomes live at once
          cfg_q.dyn_addr  <= cfg_wr_i.value[i3c_target_pkg::ADDR_W-1:0];
          cfg_q.dyn_valid <= 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  assign sta_hit = (bus_addr_i == cfg_q.static_addr);
  assign dyn_hit = cfg_q.dyn_valid && (bus_addr_i == cfg_q.dyn_addr);

  assign addr_match_o = cfg_q.enable && (sta_hit || dyn_hit);
  assign cfg_o        = cfg_q;

endmodule

// File: i3c_target_fsm.sv
// SDR target engine, I2C-style ACK and no T-bit parity; SCL low must outlast a 15-cycle ACK wait
module i3c_target_fsm (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  i3c_target_pkg::bus_evt_t            evt_i,
  input  i3c_target_pkg::target_cfg_t         cfg_i,
  input  logic                                addr_match_i,
  output logic [i3c_target_pkg::ADDR_W-1:0]   bus_addr_o,
  output logic                                sda_o,
  output i3c_target_pkg::rx_byte_t            rx_byte_o,
  input  logic                                rx_space_i,
  output logic                                tx_req_o,
  input  logic [7:0]                          tx_byte_i
);

  i3c_target_pkg::tgt_state_e state_q;
  i3c_target_pkg::xfer_t      xfer_q;
  logic [7:0]                 rx_sh_q;
  logic [7:0]                 tx_sh_q;
  logic [3:0]                 bit_cnt_q;
  logic [7:0]                 hold_q;
  logic                       hold_vld_q;
  logic [3:0]                 dec_cnt_q;
  logic                       sda_q;
  logic                       flush;

  assign bus_addr_o = rx_sh_q[7:1];
  assign sda_o      = sda_q;

  // Held write byte is closed by STOP or repeated START
  assign flush = (evt_i.start || evt_i.stop) && hold_vld_q && xfer_q.active && !xfer_q.rnw;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= i3c_target_pkg::ST_IDLE;
      xfer_q     <= '0;
      bit_cnt_q  <= '0;
      hold_vld_q <= 1'b0;
      dec_cnt_q  <= '0;
      sda_q      <= 1'b1;
      rx_byte_o  <= '0;
      tx_req_o   <= 1'b0;
    end else begin
      rx_byte_o.valid <= 1'b0;
      rx_byte_o.last  <= 1'b0;
      tx_req_o        <= 1'b0;

      if (flush) begin
        rx_byte_o  <= '{valid: 1'b1, data: hold_q, last: 1'b1};
        hold_vld_q <= 1'b0;
      end

      if (evt_i.stop || (evt_i.start && !cfg_i.enable)) begin
        state_q <= i3c_target_pkg::ST_IDLE;
        xfer_q  <= '0;
        sda_q   <= 1'b1;
      end else if (evt_i.start) begin
        state_q   <= i3c_target_pkg::ST_ADDR;
        xfer_q    <= '0;
        bit_cnt_q <= '0;
        sda_q     <= 1'b1;
      end else begin
        case (state_q)
          i3c_target_pkg::ST_ADDR: begin
            if (evt_i.scl_rise) begin
              rx_sh_q   <= {rx_sh_q[6:0], evt_i.sda};
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (evt_i.scl_fall && bit_cnt_q == 4'd8) begin
              if (addr_match_i) begin
                sda_q   <= 1'b0;
                xfer_q  <= '{active: 1'b1, rnw: rx_sh_q[0]};
                state_q <= i3c_target_pkg::ST_ADDR_ACK;
              end else begin
                state_q <= i3c_target_pkg::ST_IDLE;
              end
            end
          end
          i3c_target_pkg::ST_ADDR_ACK: begin
            if (evt_i.scl_fall && xfer_q.rnw) begin
              // First read bit goes out in the same low phase
              tx_sh_q   <= tx_byte_i;
              sda_q     <= tx_byte_i[7];
              tx_req_o  <= 1'b1;
              bit_cnt_q <= 4'd1;
              state_q   <= i3c_target_pkg::ST_RDATA;
            end else if (evt_i.scl_fall) begin
              sda_q     <= 1'b1;
              bit_cnt_q <= '0;
              state_q   <= i3c_target_pkg::ST_WDATA;
            end
          end
          i3c_target_pkg::ST_WDATA: begin
            if (evt_i.scl_rise) begin
              rx_sh_q   <= {rx_sh_q[6:0], evt_i.sda};
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (evt_i.scl_fall && bit_cnt_q == 4'd8) begin
              // A following byte proves the held one was not last
              if (hold_vld_q) begin
                rx_byte_o <= '{valid: 1'b1, data: hold_q, last: 1'b0};
              end
              hold_vld_q <= 1'b0;
              hold_q     <= rx_sh_q;
              dec_cnt_q  <= 4'd10;
              state_q    <= i3c_target_pkg::ST_WACK;
            end
          end
          i3c_target_pkg::ST_WACK: begin
            if (dec_cnt_q != 4'd0) begin
              dec_cnt_q <= dec_cnt_q - 4'd1;
              // Space is polled once the flow has seen the released byte
              if (dec_cnt_q != 4'd10 && rx_space_i) begin
                sda_q      <= 1'b0;
                hold_vld_q <= 1'b1;
                dec_cnt_q  <= 4'd0;
              end else if (dec_cnt_q == 4'd1) begin
                // No space before the ACK slot closes
                state_q <= i3c_target_pkg::ST_IDLE;
              end
            end else if (evt_i.scl_fall) begin
              sda_q     <= 1'b1;
              bit_cnt_q <= '0;
              state_q   <= i3c_target_pkg::ST_WDATA;
            end
          end
          i3c_target_pkg::ST_RDATA: begin
            if (evt_i.scl_fall && bit_cnt_q == 4'd8) begin
              sda_q   <= 1'b1;
              state_q <= i3c_target_pkg::ST_RACK;
            end else if (evt_i.scl_fall) begin
              sda_q     <= tx_sh_q[6];
              tx_sh_q   <= {tx_sh_q[6:0], 1'b1};
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end
          end
          i3c_target_pkg::ST_RACK: begin
            if (evt_i.scl_rise && evt_i.sda) begin
              // Controller NACK ends the read
              state_q <= i3c_target_pkg::ST_IDLE;
            end else if (evt_i.scl_fall) begin
              tx_sh_q   <= tx_byte_i;
              sda_q     <= tx_byte_i[7];
              tx_req_o  <= 1'b1;
              bit_cnt_q <= 4'd1;
              state_q   <= i3c_target_pkg::ST_RDATA;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// File: i3c_tti_flow.sv
// Byte to word packing for the RX queue and word to byte unpacking for TX; empty TX reads as FF
module i3c_tti_flow (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  i3c_target_pkg::rx_byte_t            rx_byte_i,
  output logic                                rx_space_o,
  input  logic                                tx_req_i,
  output logic [7:0]                          tx_byte_o,
  output logic                                rx_wvalid_o,
  output logic [i3c_target_pkg::DATA_W-1:0]   rx_wdata_o,
  input  logic                                rx_wready_i,
  input  logic                                tx_rvalid_i,
  input  logic [i3c_target_pkg::DATA_W-1:0]   tx_rdata_i,
  output logic                                tx_rready_o
);

  logic [i3c_target_pkg::DATA_W-1:0]     pack_q;
  logic [i3c_target_pkg::DATA_W-1:0]     pack_merged;
  logic [i3c_target_pkg::DATA_W-1:0]     tx_word_q;
  logic [i3c_target_pkg::BYTE_IDX_W-1:0] rx_cnt_q;
  logic [i3c_target_pkg::BYTE_IDX_W-1:0] tx_idx_q;
  logic                                  tx_have_q;
  logic                                  rx_take;
  logic                                  word_done;

  always_comb begin
    pack_merged = pack_q;
    pack_merged[{rx_cnt_q, 3'b000} +: 8] = rx_byte_i.data;
  end

  assign rx_space_o = !rx_wvalid_o;
  assign rx_take    = rx_byte_i.valid && rx_space_o;
  assign word_done  = rx_take && (rx_byte_i.last || rx_cnt_q == i3c_target_pkg::LAST_BYTE_IDX);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pack_q      <= '0;
      rx_cnt_q    <= '0;
      rx_wvalid_o <= 1'b0;
    end else begin
      if (rx_wvalid_o && rx_wready_i) begin
        rx_wvalid_o <= 1'b0;
      end
      if (word_done) begin
        // Cleared packer leaves unused upper bytes zero on a flush
        rx_wvalid_o <= 1'b1;
        pack_q      <= '0;
        rx_cnt_q    <= '0;
      end else if (rx_take) begin
        pack_q   <= pack_merged;
        rx_cnt_q <= rx_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_done) begin
      rx_wdata_o <= pack_merged;
    end
    if (tx_rready_o) begin
      tx_word_q <= tx_rdata_i;
    end
  end

  assign tx_byte_o = tx_have_q ? tx_word_q[{tx_idx_q, 3'b000} +: 8] : 8'hFF;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_have_q   <= 1'b0;
      tx_idx_q    <= '0;
      tx_rready_o <= 1'b0;
    end else begin
      tx_rready_o <= tx_rvalid_i && !tx_have_q && !tx_rready_o;
      if (tx_rready_o) begin
        tx_have_q <= 1'b1;
        tx_idx_q  <= '0;
      end else if (tx_req_i && tx_have_q) begin
        // LSB first, refill after the top byte
        tx_idx_q <= tx_idx_q + 1'b1;
        if (tx_idx_q == i3c_target_pkg::LAST_BYTE_IDX) begin
          tx_have_q <= 1'b0;
        end
      end
    end
  end

endmodule

// File: i3c_standby_target.sv
// Standby target top; open-drain outputs where 1 releases the line, SCL is never driven low
module i3c_standby_target (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  i3c_target_pkg::cfg_wr_t             cfg_wr_i,
  input  logic                                scl_i,
  input  logic                                sda_i,
  output logic                                scl_o,
  output logic                                sda_o,
  output logic                                rx_wvalid_o,
  output logic [i3c_target_pkg::DATA_W-1:0]   rx_wdata_o,
  input  logic                                rx_wready_i,
  input  logic                                tx_rvalid_i,
  input  logic [i3c_target_pkg::DATA_W-1:0]   tx_rdata_i,
  output logic                                tx_rready_o
);

  i3c_target_pkg::bus_evt_t         evt;
  i3c_target_pkg::target_cfg_t      cfg;
  i3c_target_pkg::rx_byte_t         rx_byte;
  logic [i3c_target_pkg::ADDR_W-1:0] bus_addr;
  logic                             addr_match;
  logic                             rx_space;
  logic                             tx_req;
  logic [7:0]                       tx_byte;

  // No clock stretching
  assign scl_o = 1'b1;

  i3c_bus_monitor u_monitor (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .evt_o   (evt)
  );

  i3c_addr_cfg u_cfg (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_wr_i     (cfg_wr_i),
    .bus_addr_i   (bus_addr),
    .cfg_o        (cfg),
    .addr_match_o (addr_match)
  );

  i3c_target_fsm u_fsm (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .evt_i        (evt),
    .cfg_i        (cfg),
    .addr_match_i (addr_match),
    .bus_addr_o   (bus_addr),
    .sda_o        (sda_o),
    .rx_byte_o    (rx_byte),
    .rx_space_i   (rx_space),
    .tx_req_o     (tx_req),
    .tx_byte_i    (tx_byte)
  );

  i3c_tti_flow u_flow (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rx_byte_i   (rx_byte),
    .rx_space_o  (rx_space),
    .tx_req_i    (tx_req),
    .tx_byte_o   (tx_byte),
    .rx_wvalid_o (rx_wvalid_o),
    .rx_wdata_o  (rx_wdata_o),
    .rx_wready_i (rx_wready_i),
    .tx_rvalid_i (tx_rvalid_i),
    .tx_rdata_i  (tx_rdata_i),
    .tx_rready_o (tx_rready_o)
  );

endmodule

// File: i3c_standby_target_sva.sv
// Protocol assertions bound into the standby target; inactive while reset is asserted
module i3c_standby_target_sva (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        rx_wvalid_i,
  input logic        rx_wready_i,
  input logic [31:0] rx_wdata_i,
  input logic        tx_rvalid_i,
  input logic        tx_rready_i,
  input logic        sda_i,
  input logic        fsm_idle_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Word held until the queue takes it
  wdata_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rx_wvalid_i && !rx_wready_i) |=> $stable(rx_wdata_i))
    else $error("RX word changed while waiting for wready");

  pop_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_rready_i |-> tx_rvalid_i)
    else $error("TX pop issued with the TX queue empty");

  idle_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fsm_idle_i |-> sda_i)
    else $error("SDA pulled low while the target FSM is idle");

endmodule

bind i3c_standby_target i3c_standby_target_sva u_sva (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .rx_wvalid_i (rx_wvalid_o),
  .rx_wready_i (rx_wready_i),
  .rx_wdata_i  (rx_wdata_o),
  .tx_rvalid_i (tx_rvalid_i),
  .tx_rready_i (tx_rready_o),
  .sda_i       (sda_o),
  .fsm_idle_i  (u_fsm.state_q == i3c_target_pkg::ST_IDLE)
);

// File: tb_i3c_standby_target.sv
// Bus controller model at SCL half-period of 16 clocks; expects the fifth byte NACKed under held wready
module tb_i3c_standby_target;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS    = 10;
  localparam int MAX_BYTES   = 9;
  localparam int BIT_CYCLES  = 32;
  localparam int CLK_NS      = 8;
  localparam int WATCHDOG_NS = 2 * NUM_ROWS * MAX_BYTES * 9 * BIT_CYCLES * CLK_NS;
  localparam int TX_WORDS    = 2;

  typedef struct packed {
    logic        do_cfg;
    logic [1:0]  cfg_sel;
    logic [7:0]  cfg_val;
    logic [6:0]  addr;
    logic        rnw;
    logic        hold;
    logic [3:0]  nbytes;
    logic [63:0] payload;
    logic        exp_addr_ack;
    logic [3:0]  exp_acks;
  } row_t;

  logic                          clk;
  logic                          rst_n;
  i3c_target_pkg::cfg_wr_t       cfg_wr;
  logic                          scl_i;
  logic                          sda_i;
  logic                          scl_o;
  logic                          sda_o;
  logic                          rx_wvalid;
  logic [31:0]                   rx_wdata;
  logic                          rx_wready;
  logic                          tx_rvalid;
  logic [31:0]                   tx_rdata;
  logic                          tx_rready;
  logic                          ctrl_scl;
  logic                          ctrl_sda;
  logic                          hold;
  integer                        seed;
  int                            tx_pos;
  int                            errors;
  logic [31:0]                   rx_got[$];
  logic [31:0]                   exp_words[$];
  row_t                          rows[NUM_ROWS];

  i3c_standby_target dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .cfg_wr_i    (cfg_wr),
    .scl_i       (scl_i),
    .sda_i       (sda_i),
    .scl_o       (scl_o),
    .sda_o       (sda_o),
    .rx_wvalid_o (rx_wvalid),
    .rx_wdata_o  (rx_wdata),
    .rx_wready_i (rx_wready),
    .tx_rvalid_i (tx_rvalid),
    .tx_rdata_i  (tx_rdata),
    .tx_rready_o (tx_rready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Open-drain wired AND of controller and target
  always @(posedge clk) begin
    scl_i <= ctrl_scl & scl_o;
    sda_i <= ctrl_sda & sda_o;
  end

  // RX queue sink with random back-pressure
  always @(posedge clk) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    if (rx_wvalid && rx_wready) begin
      rx_got.push_back(rx_wdata);
    end
    rx_wready <= hold ? 1'b0 : rnd[0];
  end

  function automatic logic [31:0] tx_word(input int idx);
    case (idx)
      0:       tx_word = 32'hD3C2_B1A0;
      1:       tx_word = 32'h1F2E_3D4C;
      default: tx_word = 32'h0;
    endcase
  endfunction

  // TX queue source, popped by rready
  always @(posedge clk) begin
    int next_pos;
    next_pos = tx_rready ? tx_pos + 1 : tx_pos;
    tx_pos    <= next_pos;
    tx_rvalid <= (next_pos < TX_WORDS);
    tx_rdata  <= tx_word(next_pos);
  end

  // Bytes leave the TX queue LSB first, FF once it is empty
  function automatic logic [7:0] exp_read_byte(input int idx);
    logic [31:0] w;
    if (idx >= TX_WORDS * 4) begin
      return 8'hFF;
    end
    w = tx_word(idx / 4);
    return w[8 * (idx % 4) +: 8];
  endfunction

  function automatic logic [31:0] pack_word(input logic [63:0] payload, input int first,
                                            input int count);
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < count; k++) begin
      w[8 * k +: 8] = payload[8 * (first + k) +: 8];
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One SCL period starting and ending with SCL low
  task automatic clock_bit(input logic drive, output logic seen);
    wait_cycles(8);
    ctrl_sda <= drive;
    wait_cycles(8);
    ctrl_scl <= 1'b1;
    wait_cycles(8);
    @(negedge clk);
    seen = ctrl_sda & sda_o;
    check("scl_o", 32'(scl_o), 32'h1);
    wait_cycles(8);
    ctrl_scl <= 1'b0;
  endtask

  task automatic start_cond();
    ctrl_sda <= 1'b0;
    wait_cycles(16);
    ctrl_scl <= 1'b0;
  endtask

  task automatic stop_cond();
    wait_cycles(8);
    ctrl_sda <= 1'b0;
    wait_cycles(8);
    ctrl_scl <= 1'b1;
    wait_cycles(16);
    ctrl_sda <= 1'b1;
    wait_cycles(16);
  endtask

  task automatic send_byte(input logic [7:0] b, output logic acked);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i], seen);
    end
    clock_bit(1'b1, seen);
    acked = !seen;
  endtask

  task automatic read_byte(input logic last, output logic [7:0] b);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, seen);
      b[i] = seen;
    end
    clock_bit(last, seen);
  endtask

  task automatic write_cfg(input logic [1:0] sel, input logic [7:0] value);
    @(posedge clk);
    cfg_wr <= '{strobe: 1'b1, sel: sel, value: value};
    @(posedge clk);
    cfg_wr <= '0;
    wait_cycles(2);
  endtask

  task automatic run_row(input row_t r, inout int rd_idx);
    logic       acked;
    logic [7:0] b;
    int         n_acked;
    n_acked = 0;
    if (r.do_cfg) begin
      write_cfg(r.cfg_sel, r.cfg_val);
    end
    hold <= r.hold;
    start_cond();
    send_byte({r.addr, r.rnw}, acked);
    check("addr_ack", 32'(acked), 32'(r.exp_addr_ack));
    if (acked && r.rnw) begin
      for (int j = 0; j < int'(r.nbytes); j++) begin
        read_byte(j == int'(r.nbytes) - 1, b);
        check("read_byte", 32'(b), 32'(exp_read_byte(rd_idx)));
        rd_idx++;
      end
    end else if (acked) begin
      for (int j = 0; j < int'(r.nbytes); j++) begin
        send_byte(r.payload[8 * j +: 8], acked);
        if (!acked) begin
          break;
        end
        n_acked++;
      end
      check("data_acks", 32'(n_acked), 32'(r.exp_acks));
      for (int k = 0; k < n_acked; k += 4) begin
        exp_words.push_back(pack_word(r.payload, k, (n_acked - k > 4) ? 4 : n_acked - k));
      end
    end
    stop_cond();
    hold <= 1'b0;
  endtask

  initial begin
    seed      = 32'h5370_936b;
    rst_n     = 1'b0;
    cfg_wr    = '0;
    ctrl_scl  = 1'b1;
    ctrl_sda  = 1'b1;
    scl_i     = 1'b1;
    sda_i     = 1'b1;
    rx_wready = 1'b0;
    tx_rvalid = 1'b0;
    tx_rdata  = '0;
    tx_pos    = 0;
    hold      = 1'b0;
    errors    = 0;
    // cfg, sel, val, addr, rnw, hold, n, payload, addr ack, data acks
    rows[0] = '{1'b1, 2'd1, 8'h2A, 7'h2A, 1'b0, 1'b0, 4'd4, 64'h0000_0000_4433_2211, 1'b1, 4'd4};
    rows[1] = '{1'b0, 2'd0, 8'h00, 7'h15, 1'b0, 1'b0, 4'd2, 64'h0000_0000_0000_BBAA, 1'b0, 4'd0};
    rows[2] = '{1'b0, 2'd0, 8'h00, 7'h2A, 1'b0, 1'b0, 4'd6, 64'h0000_F6E5_D4C3_B2A1, 1'b1, 4'd6};
    rows[3] = '{1'b1, 2'd2, 8'h33, 7'h33, 1'b0, 1'b0, 4'd3, 64'h0000_0000_000C_0B0A, 1'b1, 4'd3};
    rows[4] = '{1'b0, 2'd0, 8'h00, 7'h2A, 1'b0, 1'b0, 4'd2, 64'h0000_0000_0000_5AA5, 1'b1, 4'd2};
    rows[5] = '{1'b1, 2'd0, 8'h00, 7'h33, 1'b0, 1'b0, 4'd1, 64'h0000_0000_0000_0077, 1'b0, 4'd0};
    rows[6] = '{1'b0, 2'd0, 8'h00, 7'h2A, 1'b0, 1'b0, 4'd1, 64'h0000_0000_0000_0088, 1'b0, 4'd0};
    rows[7] = '{1'b1, 2'd0, 8'h01, 7'h2A, 1'b1, 1'b0, 4'd8, 64'h0, 1'b1, 4'd8};
    rows[8] = '{1'b0, 2'd0, 8'h00, 7'h33, 1'b1, 1'b0, 4'd3, 64'h0, 1'b1, 4'd3};
    rows[9] = '{1'b0, 2'd0, 8'h00, 7'h2A, 1'b0, 1'b1, 4'd6, 64'h0000_9F8E_7D6C_5B4A, 1'b1, 4'd4};
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    wait_cycles(8);
    write_cfg(i3c_target_pkg::CFG_SEL_CTRL, 8'h01);
    begin
      int rd_idx;
      rd_idx = 0;
      for (int r = 0; r < NUM_ROWS; r++) begin
        run_row(rows[r], rd_idx);
        while (rx_got.size() < exp_words.size()) begin
          @(posedge clk);
        end
        wait_cycles(32);
        check("rx_word_count", 32'(rx_got.size()), 32'(exp_words.size()));
      end
    end
    foreach (exp_words[i]) begin
      check("rx_wdata", rx_got[i], exp_words[i]);
    end
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the bus transfers did not finish in time");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: i3c_standby_target.f
i3c_target_pkg.sv
i3c_bus_monitor.sv
i3c_addr_cfg.sv
i3c_target_fsm.sv
i3c_tti_flow.sv
i3c_standby_target.sv
i3c_standby_target_sva.sv
tb_i3c_standby_target.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f i3c_standby_target.f \
  --top-module tb_i3c_standby_target -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo ">>> FAIL" >> sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
